// File: arrayMemory.f
+incdir+design
design/memoryPkg.sv
design/requestCheck.sv
design/elementStore.sv
design/elementExecute.sv
design/arrayMemory.sv
testbench/arrayMemoryTb.sv

// File: design/arrayMemory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Array memory top level. A Wishbone classic host sends one command
// at a time; check, memory read and execute stages answer with ack.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "memorySettings.svh"

module arrayMemory (
  input  logic              clock,
  input  logic              reset,                                  // Synchronous, active high
  input  logic              cyc,
  input  logic              stb,
  input  memoryPkg::actionT action,
  input  memoryPkg::arrayT  array,
  input  memoryPkg::indexT  index,
  input  memoryPkg::dataT   dataIn,
  output memoryPkg::dataT   dataOut,
  output memoryPkg::errorT  error,
  output logic              ack                                     // One cycle per request
);
  import memoryPkg::*;

  logic   checkValid;                                               // Stage one to stage two
  actionT checkAction;
  arrayT  checkArray;
  indexT  checkIndex;
  dataT   checkData;
  errorT  checkError;

  logic   storeValid;                                               // Stage two to stage three
  actionT storeAction;
  arrayT  storeArray;
  indexT  storeIndex;
  dataT   storeData;
  errorT  storeError;
  dataT   readData;

  logic   writeEnable;                                              // Write-back from stage three
  arrayT  writeArray;
  indexT  writeIndex;
  dataT   writeData;

  requestCheck check (
    .clock, .reset, .cyc, .stb, .action, .array, .index, .dataIn, .ack,
    .checkValid, .checkAction, .checkArray, .checkIndex, .checkData, .checkError
  );

  elementStore store (
    .clock,
    .checkValid, .checkAction, .checkArray, .checkIndex, .checkData, .checkError,
    .writeEnable, .writeArray, .writeIndex, .writeData,
    .readData,
    .storeValid, .storeAction, .storeData, .storeError, .storeArray, .storeIndex
  );

  elementExecute execute (
    .clock, .reset,
    .storeValid, .storeAction, .storeData, .storeError, .storeArray, .storeIndex,
    .readData,
    .writeEnable, .writeArray, .writeIndex, .writeData,
    .dataOut, .error, .ack
  );

endmodule

// File: design/elementExecute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage three. Forms the result and the write-back value from the
// stored element, writes it back and answers the host with ack.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "memorySettings.svh"

module elementExecute (
  input  logic              clock,
  input  logic              reset,
  input  logic              storeValid,
  input  memoryPkg::actionT storeAction,
  input  memoryPkg::dataT   storeData,                              // Host data or stage one result
  input  memoryPkg::errorT  storeError,
  input  memoryPkg::arrayT  storeArray,
  input  memoryPkg::indexT  storeIndex,
  input  memoryPkg::dataT   readData,                               // Current element value
  output logic              writeEnable,
  output memoryPkg::arrayT  writeArray,
  output memoryPkg::indexT  writeIndex,
  output memoryPkg::dataT   writeData,
  output memoryPkg::dataT   dataOut,
  output memoryPkg::errorT  error,
  output logic              ack
);
  import memoryPkg::*;

  logic writesElement;                                              // Action updates the slot
  dataT newValue;
  dataT result;

  always_comb begin
    writesElement = 1'b0;
    newValue      = readData;
    result        = '0;
    case (storeAction)
      Write: begin
        writesElement = 1'b1;
        newValue      = storeData;
        result        = storeData;
      end
      Read, Pop: result = readData;
      Push: begin                                                   // Returns 0
        writesElement = 1'b1;
        newValue      = storeData;
      end
      Add, AddAfter: begin
        writesElement = 1'b1;
        newValue      = readData + storeData;                       // Wraps at 16 bits
        result        = (storeAction == Add) ? newValue : readData;
      end
      Subtract, SubAfter: begin
        writesElement = 1'b1;
        newValue      = readData - storeData;
        result        = (storeAction == Subtract) ? newValue : readData;
      end
      Not, Or, Xor, And: begin
        writesElement = 1'b1;
        case (storeAction)
          Not:     newValue = ~readData;
          Or:      newValue = readData | storeData;
          Xor:     newValue = readData ^ storeData;
          default: newValue = readData & storeData;
        endcase
        result = newValue;
      end
      Size, Alloc: result = storeData;
      default: ;                                                    // Free returns 0
    endcase
  end

  assign writeEnable = storeValid && storeError == None && writesElement;
  assign writeArray  = storeArray;
  assign writeIndex  = storeIndex;
  assign writeData   = newValue;

  always_ff @(posedge clock) begin
    if (reset) begin
      ack     <= 1'b0;
      error   <= None;
      dataOut <= '0;
    end else begin
      ack <= storeValid;                                            // Single cycle pulse
      if (storeValid) begin
        error   <= storeError;
        dataOut <= (storeError == None) ? result : '0;
      end
    end
  end

endmodule

// File: design/elementStore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage two. Flat element storage with a registered read port and a
// write port fed back from stage three; command fields pass through.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "memorySettings.svh"

module elementStore (
  input  logic              clock,
  input  logic              checkValid,
  input  memoryPkg::actionT checkAction,
  input  memoryPkg::arrayT  checkArray,
  input  memoryPkg::indexT  checkIndex,
  input  memoryPkg::dataT   checkData,
  input  memoryPkg::errorT  checkError,
  input  logic              writeEnable,
  input  memoryPkg::arrayT  writeArray,
  input  memoryPkg::indexT  writeIndex,
  input  memoryPkg::dataT   writeData,
  output memoryPkg::dataT   readData,                               // Valid one edge after checkValid
  output logic              storeValid,
  output memoryPkg::actionT storeAction,
  output memoryPkg::dataT   storeData,
  output memoryPkg::errorT  storeError,
  output memoryPkg::arrayT  storeArray,
  output memoryPkg::indexT  storeIndex
);
  import memoryPkg::*;

  dataT storage [ARRAYS * ARRAY_LENGTH];                            // Array blocks back to back

  logic [`ADDRESS_BITS+`INDEX_BITS-1:0] readAddress;
  logic [`ADDRESS_BITS+`INDEX_BITS-1:0] writeAddress;

  assign readAddress  = {checkArray, checkIndex};
  assign writeAddress = {writeArray, writeIndex};

  always_ff @(posedge clock) begin
    if (writeEnable) storage[writeAddress] <= writeData;
    readData    <= storage[readAddress];
    storeValid  <= checkValid;
    storeAction <= checkAction;
    storeData   <= checkData;
    storeError  <= checkError;
    storeArray  <= checkArray;
    storeIndex  <= checkIndex;
  end

endmodule

// File: design/memoryPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the array memory. Holds the action codes, error
// kinds and the array, index, size and element widths of every stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "memorySettings.svh"

package memoryPkg;

  localparam int ARRAYS       = 1 << `ADDRESS_BITS;                 // Arrays held
  localparam int ARRAY_LENGTH = 1 << `INDEX_BITS;                   // Elements per array

  typedef logic [`ADDRESS_BITS-1:0] arrayT;                         // Array number
  typedef logic [`INDEX_BITS-1:0]   indexT;                         // Element index
  typedef logic [`INDEX_BITS:0]     sizeT;                          // Zero up to full
  typedef logic [`DATA_BITS-1:0]    dataT;                          // One element

  // Host command codes
  typedef enum logic [7:0] {
    Write    = 8'd2,                                                // Store an element
    Read     = 8'd3,                                                // Fetch an element
    Size     = 8'd4,                                                // Current array size
    Push     = 8'd14,                                               // Append at the top
    Pop      = 8'd15,                                               // Remove from the top
    Alloc    = 8'd18,                                               // Claim the lowest free array
    Free     = 8'd19,                                               // Release an array
    Add      = 8'd20,                                               // Returns new value
    AddAfter = 8'd21,                                               // Returns old value
    Subtract = 8'd22,                                               // Returns new value
    SubAfter = 8'd23,                                               // Returns old value
    Not      = 8'd27,                                               // Bitwise invert
    Or       = 8'd28,
    Xor      = 8'd29,
    And      = 8'd30
  } actionT;

  // Reported with ack and None when the command took effect
  typedef enum logic [2:0] {
    None,
    NotAllocated,                                                   // Array never allocated or freed
    OutOfBounds,                                                    // Index at or past size
    ArrayFull,                                                      // Push onto a full array
    ArrayEmpty,                                                     // Pop from an empty array
    OutOfMemory,                                                    // No array left for Alloc
    DoubleFree                                                      // Free of a free array
  } errorT;

endpackage

// File: design/memorySettings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width settings for the array memory. Include this file before
// importing the package or sizing any storage from the widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MEMORY_SETTINGS_SVH
`define MEMORY_SETTINGS_SVH

// Bits in an array number for 8 arrays
`define ADDRESS_BITS 3

// Bits in an element index for 8 elements per array
`define INDEX_BITS 3

// Width of one element
`define DATA_BITS 16

// All per-array counts derive from these three
// Changing them resizes the bitmap, the size table and the storage
// The host ports follow automatically through the package types

`endif

// File: design/requestCheck.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage one. Accepts a host command, checks it against the allocation
// bitmap and array sizes, serves Alloc and Free, and resolves the slot.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "memorySettings.svh"

module requestCheck (
  input  logic              clock,
  input  logic              reset,
  input  logic              cyc,
  input  logic              stb,
  input  memoryPkg::actionT action,
  input  memoryPkg::arrayT  array,
  input  memoryPkg::indexT  index,
  input  memoryPkg::dataT   dataIn,
  input  logic              ack,                                    // Ends the busy period
  output logic              checkValid,                             // One cycle per accepted command
  output memoryPkg::actionT checkAction,
  output memoryPkg::arrayT  checkArray,
  output memoryPkg::indexT  checkIndex,                             // Resolved slot index
  output memoryPkg::dataT   checkData,
  output memoryPkg::errorT  checkError
);
  import memoryPkg::*;

  logic              busy;                                          // Request in flight
  logic [ARRAYS-1:0] allocated;                                     // Allocation bitmap
  sizeT              sizes [ARRAYS];

  logic  accept;
  sizeT  curSize;
  logic  freeFound;
  arrayT freeArray;                                                 // Lowest free array
  indexT slotIndex;
  dataT  resultData;
  errorT nextError;

  assign accept  = cyc && stb && !busy;
  assign curSize = sizes[array];

  // Lowest free array wins the priority search
  always_comb begin
    freeFound = 1'b0;
    freeArray = '0;
    for (int i = ARRAYS - 1; i >= 0; i--) begin
      if (!allocated[i]) begin
        freeFound = 1'b1;
        freeArray = arrayT'(i);
      end
    end
  end

  always_comb begin
    slotIndex  = index;
    resultData = dataIn;
    nextError  = None;
    case (action)
      Alloc: begin
        if (!freeFound) nextError = OutOfMemory;
        else resultData = dataT'(freeArray);                        // Array number goes back to host
      end
      Free: if (!allocated[array]) nextError = DoubleFree;
      default: begin
        if (!allocated[array]) begin
          nextError = NotAllocated;
        end else begin
          case (action)
            Read, Add, AddAfter, Subtract, SubAfter, Not, Or, Xor, And:
              if (sizeT'(index) >= curSize) nextError = OutOfBounds;
            Push: begin
              if (curSize == sizeT'(ARRAY_LENGTH)) nextError = ArrayFull;
              slotIndex = indexT'(curSize);                         // Next free slot
            end
            Pop: begin
              if (curSize == '0) nextError = ArrayEmpty;
              else slotIndex = indexT'(curSize - sizeT'(1));        // Top element
            end
            Size: resultData = dataT'(curSize);
            default: ;
          endcase
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= 1'b0;
      checkValid <= 1'b0;
      checkError <= None;
      allocated  <= '0;
      for (int i = 0; i < ARRAYS; i++) sizes[i] <= '0;
    end else begin
      checkValid <= accept;
      if (accept) busy <= 1'b1;
      else if (ack) busy <= 1'b0;
      if (accept) begin
        checkError <= nextError;
        if (nextError == None) begin                                // Errors leave state alone
          case (action)
            Alloc: begin
              allocated[freeArray] <= 1'b1;
              sizes[freeArray]     <= '0;
            end
            Free:  allocated[array] <= 1'b0;
            Write: if (sizeT'(index) >= curSize) sizes[array] <= sizeT'(index) + sizeT'(1);
            Push:  sizes[array] <= curSize + sizeT'(1);
            Pop:   sizes[array] <= curSize - sizeT'(1);
            default: ;
          endcase
        end
      end
    end
  end

  // Command fields ride along with the check result
  always_ff @(posedge clock) begin
    if (accept) begin
      checkAction <= action;
      checkArray  <= array;
      checkIndex  <= slotIndex;
      checkData   <= resultData;
    end
  end

endmodule

// File: testbench/arrayMemoryTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the array memory. Reads commands and expected results
// from the tests file, runs each through the Wishbone classic handshake.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module arrayMemoryTb;
  import memoryPkg::*;

  logic   clock;
  logic   reset;
  logic   cyc;
  logic   stb;
  actionT action;
  arrayT  array;
  indexT  index;
  dataT   dataIn;
  dataT   dataOut;
  errorT  error;
  logic   ack;

  logic [7:0] codeQ [$];                                            // Action code or 00 for reset
  arrayT      arrayQ [$];
  indexT      indexQ [$];
  dataT       dataInQ [$];
  dataT       expDataQ [$];
  errorT      expErrorQ [$];

  int cycleCount = 0;
  int cycleLimit = 0;                                               // Set once the tests are read
  int passCount  = 0;
  int failCount  = 0;

  arrayMemory UUT (
    .clock, .reset, .cyc, .stb, .action, .array, .index, .dataIn,
    .dataOut, .error, .ack
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Done: errors found");
      $finish;
    end
  end

  // Holds reset for 8 cycles in the middle of a run
  task automatic pulseReset(input int n);
    begin
      @(posedge clock);
      reset <= 1'b1;
      repeat (8) @(posedge clock);
      reset <= 1'b0;
      $display("Test %0d: reset applied", n + 1);
    end
  endtask

  task automatic runCommand(input int n);
    actionT act;
    errorT  expErr;
    int     startCycle;
    logic   bad;
    begin
      act    = actionT'(codeQ[n]);
      expErr = expErrorQ[n];
      bad    = 1'b0;
      @(posedge clock);
      cyc    <= 1'b1;
      stb    <= 1'b1;
      action <= act;
      array  <= arrayQ[n];
      index  <= indexQ[n];
      dataIn <= dataInQ[n];
      @(negedge clock);
      startCycle = cycleCount;
      while (ack !== 1'b1) @(negedge clock);
      // Ack three edges after the request is presented
      assert (cycleCount - startCycle == 3) else begin
        $display("Test %0d: ack came %0d cycles after the request instead of 3",
                 n + 1, cycleCount - startCycle);
        bad = 1'b1;
      end
      assert (dataOut === expDataQ[n]) else begin
        $display("** Error at %0t: dataOut expected %h, actual %h", $time, expDataQ[n], dataOut);
        bad = 1'b1;
      end
      assert (error === expErr) else begin
        $display("** Error at %0t: error expected %s, actual %s", $time, expErr.name(),
                 error.name());
        bad = 1'b1;
      end
      @(posedge clock);
      cyc <= 1'b0;                                                  // Idle for one cycle
      stb <= 1'b0;
      @(negedge clock);
      assert (ack === 1'b0) else begin
        $display("Test %0d: ack stayed high for more than one cycle", n + 1);
        bad = 1'b1;
      end
      $display("Test %0d: %s array %0d index %0d %s", n + 1, act.name(), arrayQ[n],
               indexQ[n], bad ? "FAILED" : "ok");
      if (bad) failCount++;
      else passCount++;
    end
  endtask

  initial begin
    int    fd;
    string line;
    int    code, arr, idx, din, dout, err;
    cyc    = 1'b0;
    stb    = 1'b0;
    reset  = 1'b1;
    action = Write;
    array  = '0;
    index  = '0;
    dataIn = '0;
    fd = $fopen("testbench/arrayMemoryTests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file testbench/arrayMemoryTests.txt");
      $display("Done: errors found");
      $finish;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h", code, arr, idx, din, dout, err) == 6) begin
          codeQ.push_back(code[7:0]);
          arrayQ.push_back(arrayT'(arr));
          indexQ.push_back(indexT'(idx));
          dataInQ.push_back(dataT'(din));
          expDataQ.push_back(dataT'(dout));
          expErrorQ.push_back(errorT'(err));
        end
      end
      $fclose(fd);
      cycleLimit = codeQ.size() * 8 + 50;
      repeat (8) @(posedge clock);
      reset <= 1'b0;
      for (int n = 0; n < codeQ.size(); n++) begin
        if (codeQ[n] == 8'h00) pulseReset(n);
        else runCommand(n);
      end
      $display("Tests passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0) $display("Done: no errors");
      else $display("Done: errors found");
      $finish;
    end
  end

endmodule

// File: testbench/arrayMemoryTests.txt
// Hex columns: action array index dataIn expectedDataOut expectedError
// Action 00 is not a command, it pulses reset; errors 0 None .. 6 DoubleFree
12 0 0 0000 0000 0
12 0 0 0000 0001 0
12 0 0 0000 0002 0
02 2 0 abcd abcd 0
13 1 0 0000 0000 0
12 0 0 0000 0001 0
13 2 0 0000 0000 0
13 2 0 0000 0000 6
02 2 0 1111 0000 1
03 5 0 0000 0000 1
02 0 4 fff8 fff8 0
04 0 0 0000 0005 0
03 0 4 0000 fff8 0
03 0 6 0000 0000 2
14 0 4 0010 0008 0
15 0 4 0010 0008 0
03 0 4 0000 0018 0
16 0 4 0020 fff8 0
17 0 4 0ff8 fff8 0
03 0 4 0000 f000 0
1c 0 4 00f0 f0f0 0
1d 0 4 ffff 0f0f 0
1e 0 4 00ff 000f 0
1b 0 4 0000 fff0 0
0f 1 0 0000 0000 4
0e 1 0 aaaa 0000 0
0e 1 0 bbbb 0000 0
0f 1 0 0000 bbbb 0
0f 1 0 0000 aaaa 0
02 1 7 7777 7777 0
0e 1 0 0001 0000 3
0f 1 0 0000 7777 0
12 0 0 0000 0002 0
02 2 4 5555 5555 0
03 2 0 0000 abcd 0
12 0 0 0000 0003 0
12 0 0 0000 0004 0
12 0 0 0000 0005 0
12 0 0 0000 0006 0
12 0 0 0000 0007 0
12 0 0 0000 0000 5
00 0 0 0000 0000 0
04 0 0 0000 0000 1
12 0 0 0000 0000 0
